//--- include/sys1_config.svh
`ifndef SYS1_CONFIG_SVH
`define SYS1_CONFIG_SVH

// ########################################
// Download stream
// ########################################

// Byte address width of the download port
`define SYS1_DL_AW 16
// Download index that carries the game type byte
`define SYS1_GAME_IDX 1

// ########################################
// ROM map, scaled down to 256 entries a bank
// ########################################

`define SYS1_PRG_BANKS 5
`define SYS1_SND_BANKS 3
// Program banks are word addressed
`define SYS1_PRG_AW 8
// Sound banks are byte addressed
`define SYS1_SND_AW 8
// Download bytes per program bank, two per word
`define SYS1_PRG_BYTES 512
// Sound region starts right after the last program bank
`define SYS1_SND_BASE 2560

`endif

//--- hdl/sys1_pkg.sv
package sys1_pkg;

	// Cartridge types, numbered as the slapstic chips
	typedef enum logic [7:0] {
		marble   = 8'd103,
		indytemp = 8'd105,
		peterpak = 8'd107,
		roadrunn = 8'd108,
		roadb109 = 8'd109,
		roadb110 = 8'd110
	} game_t;

	// Indy layout, 000UDLR0
	typedef struct packed {
		logic [2:0] pad_hi;
		logic [3:0] dir;
		logic       pad_lo;
	} joy_shift_t;

	// All other games, 0000UDLR
	typedef struct packed {
		logic [3:0] pad;
		logic [3:0] dir;
	} joy_std_t;

	// Core joystick byte, two readings of the same word
	typedef union packed {
		joy_shift_t shifted;
		joy_std_t   standard;
	} joy_byte_t;

	// Scan codes, default arcade keyboard layout
	localparam logic [8:0] key_p1_up    = 9'h175;
	localparam logic [8:0] key_p1_down  = 9'h172;
	localparam logic [8:0] key_p1_left  = 9'h16B;
	localparam logic [8:0] key_p1_right = 9'h174;
	localparam logic [8:0] key_p1_start = 9'h014;
	localparam logic [8:0] key_p1_jump  = 9'h011;

	localparam logic [8:0] key_p2_up    = 9'h02D;
	localparam logic [8:0] key_p2_down  = 9'h02B;
	localparam logic [8:0] key_p2_left  = 9'h023;
	localparam logic [8:0] key_p2_right = 9'h034;
	localparam logic [8:0] key_p2_start = 9'h01C;
	localparam logic [8:0] key_p2_jump  = 9'h01B;

	localparam logic [8:0] key_coin_l   = 9'h02E;
	localparam logic [8:0] key_coin_r   = 9'h036;
	localparam logic [8:0] key_coin_aux = 9'h03D;

endpackage

//--- hdl/rom_download.sv
`timescale 1ns/1ps
`include "sys1_config.svh"

module rom_download (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  logic [7:0]                 dl_index,
	input  logic [`SYS1_DL_AW-1:0]     dl_addr,
	input  logic [7:0]                 dl_data,
	output logic [`SYS1_PRG_BANKS-1:0] prg_we,
	output logic [`SYS1_SND_BANKS-1:0] snd_we,
	output logic [`SYS1_PRG_AW-1:0]    wr_addr,
	output logic [15:0]                wr_word,
	output logic [7:0]                 wr_byte
);

	// Byte offset bits inside one program bank
	localparam int prg_sh = $clog2(`SYS1_PRG_BYTES);
	// Shared write address, wide enough for the sound banks too
	localparam int wr_aw  = `SYS1_PRG_AW;

	logic                   dl_rom;
	logic [7:0]             last_byte;
	logic                   in_prg;
	logic                   in_snd;
	logic [`SYS1_DL_AW-1:0] prg_bank;
	logic [`SYS1_DL_AW-1:0] snd_off;
	logic [`SYS1_DL_AW-1:0] snd_bank;

	// ROM data only travels on index 0 during a download
	assign dl_rom = dl_active && dl_wr && (dl_index == 8'd0);

	// Even byte kept as the high half of the next word
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			last_byte <= '0;
		end else if (dl_rom) begin
			last_byte <= dl_data;
		end
	end

	// ########################################
	// Region and bank decode
	// ########################################

	assign in_prg   = (dl_addr < `SYS1_SND_BASE);
	assign prg_bank = dl_addr >> prg_sh;
	assign snd_off  = dl_addr - `SYS1_DL_AW'(`SYS1_SND_BASE);
	assign snd_bank = snd_off >> `SYS1_SND_AW;
	// Past the last sound bank nothing is written
	assign in_snd   = !in_prg && (snd_bank < `SYS1_SND_BANKS);

	always_comb begin
		for (int k = 0; k < `SYS1_PRG_BANKS; k++) begin
			// Odd address closes the word
			prg_we[k] = dl_rom && in_prg && dl_addr[0] && (prg_bank == k);
		end
		for (int k = 0; k < `SYS1_SND_BANKS; k++) begin
			snd_we[k] = dl_rom && in_snd && (snd_bank == k);
		end
	end

	// Word address is the in-bank byte offset halved
	assign wr_addr = in_prg ? wr_aw'(dl_addr[prg_sh-1:1]) :
		wr_aw'(snd_off[`SYS1_SND_AW-1:0]);
	assign wr_word = {last_byte, dl_data};
	assign wr_byte = dl_data;

	// At most one bank written per strobe, across both ROM sets
	a_we_onehot: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$onehot0({prg_we, snd_we}))
		else $error("rom_download: more than one bank write strobe");

endmodule

//--- hdl/rom_bank.sv
`timescale 1ns/1ps

module rom_bank #(
	parameter int data_width = 16,
	parameter int bank_count = 5,
	parameter int addr_width = 8
) (
	input  logic                  clk_sys,
	input  logic [bank_count-1:0] we,
	input  logic [addr_width-1:0] wr_addr,
	input  logic [data_width-1:0] wr_data,
	input  logic [addr_width-1:0] rd_addr,
	input  logic [bank_count-1:0] rom_n,
	output logic [data_width-1:0] rd_data
);

	localparam int depth = 2 ** addr_width;

	logic [data_width-1:0] mem [bank_count][depth];
	logic [data_width-1:0] bank_q [bank_count];
	// Select delayed to line up with the read data
	logic [bank_count-1:0] sel_n_q;

	// ########################################
	// Download write, core read
	// ########################################

	always_ff @(posedge clk_sys) begin
		for (int k = 0; k < bank_count; k++) begin
			if (we[k]) begin
				mem[k][wr_addr] <= wr_data;
			end
			// Every bank reads, the select picks later
			bank_q[k] <= mem[k][rd_addr];
		end
		sel_n_q <= rom_n;
	end

	// Lowest active select wins, zero when idle
	always_comb begin
		rd_data = '0;
		for (int k = bank_count - 1; k >= 0; k--) begin
			if (!sel_n_q[k]) begin
				rd_data = bank_q[k];
			end
		end
	end

	// Write address known and inside the array on every strobe
	a_wr_in_range: assert property (@(posedge clk_sys)
		|we |-> (!$isunknown(wr_addr) && (int'(wr_addr) < depth)))
		else $error("rom_bank: write outside bank depth");

endmodule

//--- hdl/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [10:0] key_event,
	output logic [7:0]  p1_keys,
	output logic [7:0]  p2_keys,
	output logic [2:0]  coin_keys
);

	logic       toggle_q;
	logic       toggle;
	logic       pressed;
	logic [8:0] code;

	// Event word is toggle, pressed, scan code
	assign toggle  = key_event[10];
	assign pressed = key_event[9];
	assign code    = key_event[8:0];

	// ########################################
	// Held key state
	// ########################################

	// Player bits 7..4 are U D L R, 1 start, 0 jump
	// Coin bits are aux, right, left
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q  <= 1'b0;
			p1_keys   <= '0;
			p2_keys   <= '0;
			coin_keys <= '0;
		end else begin
			toggle_q <= toggle;
			// New event only when the toggle flips
			if (toggle_q != toggle) begin
				case (code)
					sys1_pkg::key_p1_up:    p1_keys[7] <= pressed;
					sys1_pkg::key_p1_down:  p1_keys[6] <= pressed;
					sys1_pkg::key_p1_left:  p1_keys[5] <= pressed;
					sys1_pkg::key_p1_right: p1_keys[4] <= pressed;
					sys1_pkg::key_p1_start: p1_keys[1] <= pressed;
					sys1_pkg::key_p1_jump:  p1_keys[0] <= pressed;

					sys1_pkg::key_p2_up:    p2_keys[7] <= pressed;
					sys1_pkg::key_p2_down:  p2_keys[6] <= pressed;
					sys1_pkg::key_p2_left:  p2_keys[5] <= pressed;
					sys1_pkg::key_p2_right: p2_keys[4] <= pressed;
					sys1_pkg::key_p2_start: p2_keys[1] <= pressed;
					sys1_pkg::key_p2_jump:  p2_keys[0] <= pressed;

					sys1_pkg::key_coin_aux: coin_keys[2] <= pressed;
					sys1_pkg::key_coin_r:   coin_keys[1] <= pressed;
					sys1_pkg::key_coin_l:   coin_keys[0] <= pressed;
					// Other keys are ignored
					default: ;
				endcase
			end
		end
	end

endmodule

//--- hdl/control_mapper.sv
`timescale 1ns/1ps
`include "sys1_config.svh"

module control_mapper (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                dl_wr,
	input  logic [7:0]          dl_index,
	input  logic [7:0]          dl_data,
	input  logic                service,
	input  logic [7:0]          p1_keys,
	input  logic [7:0]          p2_keys,
	input  logic [2:0]          coin_keys,
	input  logic [11:0]         joy0,
	input  logic [11:0]         joy1,
	output sys1_pkg::game_t     game_type,
	output sys1_pkg::joy_byte_t core_joy,
	output logic [2:0]          core_pb_n,
	output logic [2:0]          core_coin_n,
	output logic                core_selftest_n
);

	logic [3:0] dir;

	// Game type byte arrives on its own download index
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_type <= sys1_pkg::indytemp;
		end else if (dl_wr && (dl_index == 8'(`SYS1_GAME_IDX))) begin
			game_type <= sys1_pkg::game_t'(dl_data);
		end
	end

	// ########################################
	// Joystick byte
	// ########################################

	// Both players and both pads share one direction nibble
	assign dir = p1_keys[7:4] | p2_keys[7:4] | joy0[3:0] | joy1[3:0];

	// Indy reads its ADC one index up
	always_comb begin
		core_joy = '0;
		if (game_type == sys1_pkg::indytemp) begin
			core_joy.shifted.dir = dir;
		end else begin
			core_joy.standard.dir = dir;
		end
	end

	// Buttons and coins, all active low
	// Jump is shared by both players and both pads
	assign core_pb_n[2]    = ~(p1_keys[0] | p2_keys[0] | joy0[5] | joy1[5]);
	assign core_pb_n[1]    = ~(p2_keys[1] | joy1[4]);
	assign core_pb_n[0]    = ~(p1_keys[1] | joy0[4]);
	// Pad coin lands on the left slot
	assign core_coin_n     = ~(coin_keys | {2'b00, joy0[8]});
	assign core_selftest_n = ~service;

	// Pad bits stay clear for whichever layout the game type picks
	a_joy_pad_zero: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(game_type == sys1_pkg::indytemp) ?
			(core_joy.shifted.pad_hi == 3'b000 && !core_joy.shifted.pad_lo) :
			(core_joy.standard.pad == 4'b0000))
		else $error("control_mapper: joystick pad bits set");

endmodule

//--- hdl/sys1_host_bridge.sv
`timescale 1ns/1ps
`include "sys1_config.svh"

module sys1_host_bridge (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	// Download stream
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  logic [7:0]                 dl_index,
	input  logic [`SYS1_DL_AW-1:0]     dl_addr,
	input  logic [7:0]                 dl_data,
	// Program ROM read
	input  logic [`SYS1_PRG_AW-1:0]    prg_addr,
	input  logic [`SYS1_PRG_BANKS-1:0] prg_rom_n,
	output logic [15:0]                prg_data,
	// Sound ROM read
	input  logic [`SYS1_SND_AW-1:0]    snd_addr,
	input  logic [`SYS1_SND_BANKS-1:0] snd_rom_n,
	output logic [7:0]                 snd_data,
	// Player controls
	input  logic [10:0]                key_event,
	input  logic [11:0]                joy0,
	input  logic [11:0]                joy1,
	input  logic                       service,
	output sys1_pkg::joy_byte_t        core_joy,
	output logic [2:0]                 core_pb_n,
	output logic [2:0]                 core_coin_n,
	output logic                       core_selftest_n,
	output sys1_pkg::game_t            game_type
);

	logic [`SYS1_PRG_BANKS-1:0] prg_we;
	logic [`SYS1_SND_BANKS-1:0] snd_we;
	logic [`SYS1_PRG_AW-1:0]    wr_addr;
	logic [15:0]                wr_word;
	logic [7:0]                 wr_byte;
	logic [7:0]                 p1_keys;
	logic [7:0]                 p2_keys;
	logic [2:0]                 coin_keys;

	// ########################################
	// ROM download and storage
	// ########################################

	rom_download u_rom_download (
		.clk_sys, .arst_n, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.prg_we, .snd_we, .wr_addr, .wr_word, .wr_byte
	);

	rom_bank #(
		.data_width(16), .bank_count(`SYS1_PRG_BANKS), .addr_width(`SYS1_PRG_AW)
	) u_prg_rom (
		.clk_sys, .we(prg_we), .wr_addr(wr_addr), .wr_data(wr_word),
		.rd_addr(prg_addr), .rom_n(prg_rom_n), .rd_data(prg_data)
	);

	// Sound banks use the low bits of the shared write address
	rom_bank #(
		.data_width(8), .bank_count(`SYS1_SND_BANKS), .addr_width(`SYS1_SND_AW)
	) u_snd_rom (
		.clk_sys, .we(snd_we), .wr_addr(wr_addr[`SYS1_SND_AW-1:0]), .wr_data(wr_byte),
		.rd_addr(snd_addr), .rom_n(snd_rom_n), .rd_data(snd_data)
	);

	// ########################################
	// Controls
	// ########################################

	key_decoder u_key_decoder (
		.clk_sys, .arst_n, .key_event, .p1_keys, .p2_keys, .coin_keys
	);

	control_mapper u_control_mapper (
		.clk_sys, .arst_n, .dl_wr, .dl_index, .dl_data, .service,
		.p1_keys, .p2_keys, .coin_keys, .joy0, .joy1,
		.game_type, .core_joy, .core_pb_n, .core_coin_n, .core_selftest_n
	);

endmodule

//--- verif/tb_sys1_host_bridge.sv
`timescale 1ns/1ps
`include "sys1_config.svh"

module tb_sys1_host_bridge;

	localparam int period = 100;
	localparam int prg_depth = 2 ** `SYS1_PRG_AW;
	localparam int snd_depth = 2 ** `SYS1_SND_AW;
	localparam int shadow_len = `SYS1_SND_BASE + `SYS1_SND_BANKS * snd_depth;
	// Phase lengths in cycles, download plus read back
	localparam int prg_cycles = `SYS1_SND_BASE + `SYS1_PRG_BANKS * prg_depth + 128;
	localparam int snd_cycles = 2 * `SYS1_SND_BANKS * snd_depth + 64;
	localparam int ctl_cycles = 128;
	localparam int margin_cycles = 200;

	logic                       clk_sys = 1'b0;
	logic                       arst_n;
	logic                       dl_active;
	logic                       dl_wr;
	logic [7:0]                 dl_index;
	logic [`SYS1_DL_AW-1:0]     dl_addr;
	logic [7:0]                 dl_data;
	logic [`SYS1_PRG_AW-1:0]    prg_addr;
	logic [`SYS1_PRG_BANKS-1:0] prg_rom_n;
	logic [15:0]                prg_data;
	logic [`SYS1_SND_AW-1:0]    snd_addr;
	logic [`SYS1_SND_BANKS-1:0] snd_rom_n;
	logic [7:0]                 snd_data;
	logic [10:0]                key_event;
	logic [11:0]                joy0;
	logic [11:0]                joy1;
	logic                       service;
	sys1_pkg::joy_byte_t        core_joy;
	logic [2:0]                 core_pb_n;
	logic [2:0]                 core_coin_n;
	logic                       core_selftest_n;
	sys1_pkg::game_t            game_type;

	// Model state: download shadow, held keys {coin, p2, p1}, game type
	logic [7:0]      shadow [shadow_len];
	logic [18:0]     keys_m;
	logic            toggle_m;
	sys1_pkg::game_t game_m;
	// Pending checks, each due after the next rising edge
	string           name_q[$];
	logic [15:0]     exp_q[$];
	string           cmp_name;
	logic [15:0]     cmp_exp;
	logic [15:0]     cmp_got;
	int              checks = 0;
	int              errors = 0;
	int              tests = 0;
	int              err_mark = 0;

	sys1_host_bridge u_sys1_host_bridge (.*);

	always #(period / 2) clk_sys = ~clk_sys;

	// ########################################
	// Reference model
	// ########################################

	// First active select wins, else zero
	function automatic logic [15:0] exp_prg(input logic [`SYS1_PRG_BANKS-1:0] sel_n,
		input int addr);
		int base;
		for (int k = 0; k < `SYS1_PRG_BANKS; k++) begin
			if (!sel_n[k]) begin
				base = k * `SYS1_PRG_BYTES + 2 * addr;
				return {shadow[base], shadow[base + 1]};
			end
		end
		return '0;
	endfunction

	function automatic logic [7:0] exp_snd(input logic [`SYS1_SND_BANKS-1:0] sel_n,
		input int addr);
		for (int k = 0; k < `SYS1_SND_BANKS; k++) begin
			if (!sel_n[k]) begin
				return shadow[`SYS1_SND_BASE + k * snd_depth + addr];
			end
		end
		return '0;
	endfunction

	// Indy layout puts the nibble one bit up
	function automatic logic [7:0] exp_joy();
		logic [3:0] dir;
		dir = keys_m[7:4] | keys_m[15:12] | joy0[3:0] | joy1[3:0];
		if (game_m == sys1_pkg::indytemp) begin
			return {3'b000, dir, 1'b0};
		end
		return {4'b0000, dir};
	endfunction

	function automatic logic [2:0] exp_pb();
		return ~{keys_m[0] | keys_m[8] | joy0[5] | joy1[5],
			keys_m[9] | joy1[4], keys_m[1] | joy0[4]};
	endfunction

	// Slot in the model vector and the scan code
	function automatic logic [13:0] key_entry(input int i);
		case (i)
			0:       return {5'd7, sys1_pkg::key_p1_up};
			1:       return {5'd6, sys1_pkg::key_p1_down};
			2:       return {5'd5, sys1_pkg::key_p1_left};
			3:       return {5'd4, sys1_pkg::key_p1_right};
			4:       return {5'd1, sys1_pkg::key_p1_start};
			5:       return {5'd0, sys1_pkg::key_p1_jump};
			6:       return {5'd15, sys1_pkg::key_p2_up};
			7:       return {5'd14, sys1_pkg::key_p2_down};
			8:       return {5'd13, sys1_pkg::key_p2_left};
			9:       return {5'd12, sys1_pkg::key_p2_right};
			10:      return {5'd9, sys1_pkg::key_p2_start};
			11:      return {5'd8, sys1_pkg::key_p2_jump};
			12:      return {5'd18, sys1_pkg::key_coin_aux};
			13:      return {5'd17, sys1_pkg::key_coin_r};
			default: return {5'd16, sys1_pkg::key_coin_l};
		endcase
	endfunction

	function automatic logic [15:0] observe(input string name);
		case (name)
			"prg_data":        return prg_data;
			"snd_data":        return {8'h00, snd_data};
			"core_joy":        return {8'h00, core_joy};
			"core_pb_n":       return {13'h0000, core_pb_n};
			"core_coin_n":     return {13'h0000, core_coin_n};
			"game_type":       return {8'h00, game_type};
			"core_selftest_n": return {15'h0000, core_selftest_n};
			default:           return 'x;
		endcase
	endfunction

	// ########################################
	// Stimulus helpers
	// ########################################

	task automatic expect_val(input string name, input logic [15:0] val);
		name_q.push_back(name);
		exp_q.push_back(val);
	endtask

	task automatic expect_controls();
		expect_val("core_joy", {8'h00, exp_joy()});
		expect_val("core_pb_n", {13'h0000, exp_pb()});
		expect_val("core_coin_n", {13'h0000, ~(keys_m[18:16] | {2'b00, joy0[8]})});
		expect_val("game_type", {8'h00, game_m});
	endtask

	task automatic dl_byte(input logic [7:0] index, input int addr, input logic [7:0] data);
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_wr = 1'b1;
		dl_index = index;
		dl_addr = `SYS1_DL_AW'(addr);
		dl_data = data;
		if (index == 8'd0 && addr < shadow_len) begin
			shadow[addr] = data;
		end
	endtask

	task automatic dl_idle();
		@(negedge clk_sys);
		dl_wr = 1'b0;
		dl_active = 1'b0;
	endtask

	task automatic read_prg(input logic [`SYS1_PRG_BANKS-1:0] sel_n, input int addr);
		@(negedge clk_sys);
		prg_rom_n = sel_n;
		prg_addr = `SYS1_PRG_AW'(addr);
		expect_val("prg_data", exp_prg(sel_n, addr));
	endtask

	task automatic read_snd(input logic [`SYS1_SND_BANKS-1:0] sel_n, input int addr);
		@(negedge clk_sys);
		snd_rom_n = sel_n;
		snd_addr = `SYS1_SND_AW'(addr);
		expect_val("snd_data", {8'h00, exp_snd(sel_n, addr)});
	endtask

	// A repeat keeps the toggle bit, so the model stays put
	task automatic send_key(input int i, input logic pressed, input logic flip);
		logic [13:0] entry;
		entry = key_entry(i);
		@(negedge clk_sys);
		if (flip) begin
			toggle_m = ~toggle_m;
			keys_m[entry[13:9]] = pressed;
		end
		key_event = {toggle_m, pressed, entry[8:0]};
		expect_controls();
	endtask

	task automatic finish_test(input string name);
		@(negedge clk_sys);
		tests++;
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// ########################################
	// Compare process
	// ########################################

	// Sample a quarter period after the edge, well clear of both edges
	always @(posedge clk_sys) begin
		#(period / 4);
		while (name_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp = exp_q.pop_front();
			cmp_got = observe(cmp_name);
			checks++;
			if (cmp_got !== cmp_exp) begin
				errors++;
				$display("mismatch at %0t: %s read %h, expected %h",
					$time, cmp_name, cmp_got, cmp_exp);
			end
		end
	end

	initial begin
		#((prg_cycles + snd_cycles + ctl_cycles + margin_cycles) * period);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		int a;
		int b;
		void'($urandom(32'h7952_16a5));
		arst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		prg_addr = '0;
		prg_rom_n = '1;
		snd_addr = '0;
		snd_rom_n = '1;
		key_event = '0;
		joy0 = '0;
		joy1 = '0;
		service = 1'b0;
		keys_m = '0;
		toggle_m = 1'b0;
		game_m = sys1_pkg::indytemp;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;

		// Idle outputs straight out of reset
		@(negedge clk_sys);
		expect_controls();
		expect_val("prg_data", 16'h0000);
		expect_val("core_selftest_n", 16'h0001);
		finish_test("reset");

		// Whole program region, then each bank alone
		for (int i = 0; i < `SYS1_SND_BASE; i++) begin
			dl_byte(8'd0, i, 8'($urandom));
		end
		dl_idle();
		for (int k = 0; k < `SYS1_PRG_BANKS; k++) begin
			for (int w = 0; w < prg_depth; w++) begin
				read_prg(~(`SYS1_PRG_BANKS'(1) << k), w);
			end
		end
		// Two selects at once
		for (int n = 0; n < 16; n++) begin
			a = int'($urandom % `SYS1_PRG_BANKS);
			b = (a + 1 + int'($urandom % (`SYS1_PRG_BANKS - 1))) % `SYS1_PRG_BANKS;
			read_prg(~((`SYS1_PRG_BANKS'(1) << a) | (`SYS1_PRG_BANKS'(1) << b)),
				int'($urandom % prg_depth));
		end
		// Foreign index must not reach the banks
		for (int i = 0; i < 64; i++) begin
			dl_byte(8'd2, i, 8'($urandom));
		end
		dl_idle();
		for (int w = 0; w < 32; w++) begin
			read_prg(~`SYS1_PRG_BANKS'(1), w);
		end
		read_prg('1, 0);
		finish_test("program rom");

		for (int i = `SYS1_SND_BASE; i < shadow_len; i++) begin
			dl_byte(8'd0, i, 8'($urandom));
		end
		// Just past the last sound bank
		for (int i = 0; i < 4; i++) begin
			dl_byte(8'd0, shadow_len + i, 8'($urandom));
		end
		dl_idle();
		for (int k = 0; k < `SYS1_SND_BANKS; k++) begin
			for (int w = 0; w < snd_depth; w++) begin
				read_snd(~(`SYS1_SND_BANKS'(1) << k), w);
			end
		end
		for (int n = 0; n < 16; n++) begin
			read_snd(`SYS1_SND_BANKS'($urandom), int'($urandom % snd_depth));
		end
		read_snd('1, 0);
		finish_test("sound rom");

		// Press all, repeat each event unchanged, then release all
		for (int i = 0; i < 15; i++) begin
			send_key(i, 1'b1, 1'b1);
		end
		for (int i = 0; i < 15; i++) begin
			send_key(i, 1'b0, 1'b0);
		end
		for (int i = 0; i < 15; i++) begin
			send_key(i, 1'b0, 1'b1);
		end
		finish_test("keyboard");

		send_key(0, 1'b1, 1'b1);
		for (int n = 0; n < 32; n++) begin
			if (n == 16) begin
				dl_byte(8'(`SYS1_GAME_IDX), 0, sys1_pkg::peterpak);
				game_m = sys1_pkg::peterpak;
				expect_controls();
				dl_idle();
			end
			@(negedge clk_sys);
			joy0 = 12'($urandom);
			joy1 = 12'($urandom);
			expect_controls();
		end
		@(negedge clk_sys);
		service = 1'b1;
		expect_val("core_selftest_n", 16'h0000);
		finish_test("joystick");

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- sys1_host_bridge.f
+incdir+include
hdl/sys1_pkg.sv
hdl/rom_download.sv
hdl/rom_bank.sv
hdl/key_decoder.sv
hdl/control_mapper.sv
hdl/sys1_host_bridge.sv
verif/tb_sys1_host_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sys1_host_bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sys1_host_bridge.f \
	--top-module tb_sys1_host_bridge \
	-o tb_sys1_host_bridge

./obj_dir/tb_sys1_host_bridge > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
